//--- include/cm_defs.svh
`ifndef CM_DEFS_SVH
`define CM_DEFS_SVH

// Domain count and index width go together
`define CM_NUM_DOMAINS 4
`define CM_IDX_W       2

`define CM_RST_WIDTH   16  // Reset stretch in cycles
`define CM_LOCK_CYCLES 8   // Restart to lock in cycles

`define CM_RATIO_W     8
`define CM_DEFAULT_MUL 1
`define CM_DEFAULT_DIV 2

`endif

//--- design/cm_pkg.sv
`include "cm_defs.svh"

package cm_pkg;

   // Tick rate is mul/div, mul never above div
   typedef struct packed {
      logic [`CM_RATIO_W-1:0] mul;
      logic [`CM_RATIO_W-1:0] div;
      logic                   haltable;  // sys_halt stops this domain
   } clk_ratio_t;

   typedef struct packed {
      logic locked;
      logic tick;     // One-cycle clock enable
   } domain_status_t;

   typedef enum logic [1:0] {
      SYS_WAIT_LOCK,
      SYS_STRETCH,
      SYS_RUN
   } sys_state_e;

   // CPU reset side
   typedef enum logic [1:0] {
      CPU_HOLD,
      CPU_STRETCH,
      CPU_RUN
   } cpu_state_e;

endpackage

//--- design/ratio_config.sv
`timescale 1ns/1ps
`include "cm_defs.svh"

module ratio_config (
   input  logic                       clk_buffered,
   input  logic                       rst_locked,
   input  logic                       cfg_we,
   input  logic [`CM_IDX_W-1:0]       cfg_idx,
   input  cm_pkg::clk_ratio_t         cfg_ratio,
   output cm_pkg::clk_ratio_t         ratios [`CM_NUM_DOMAINS],
   output logic [`CM_NUM_DOMAINS-1:0] relock
);

   import cm_pkg::*;

   localparam logic [`CM_RATIO_W-1:0] DEF_MUL = `CM_DEFAULT_MUL;
   localparam logic [`CM_RATIO_W-1:0] DEF_DIV = `CM_DEFAULT_DIV;
   localparam clk_ratio_t DEF_RATIO = '{mul: DEF_MUL, div: DEF_DIV, haltable: 1'b1};

   logic [`CM_NUM_DOMAINS-1:0] wr_sel;   // One-hot write decode
   logic                       init_pend; // Restart all domains once after reset

   always_comb begin
      for (int i = 0; i < `CM_NUM_DOMAINS; i++) begin
         wr_sel[i] = cfg_we && (cfg_idx == `CM_IDX_W'(i));
      end
   end

   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         for (int i = 0; i < `CM_NUM_DOMAINS; i++) begin
            ratios[i] <= DEF_RATIO;
         end
         relock    <= '0;
         init_pend <= 1'b1;
      end else begin
         for (int i = 0; i < `CM_NUM_DOMAINS; i++) begin
            if (wr_sel[i]) begin
               ratios[i] <= cfg_ratio;  // Visible from the write edge on
            end
         end
         // Pulse lands in the cycle after the write
         relock    <= wr_sel | {`CM_NUM_DOMAINS{init_pend}};
         init_pend <= 1'b0;
      end
   end

   // A zero div or mul above div breaks the accumulator rate
   a_cfg_ratio_legal: assert property (
      @(posedge clk_buffered) disable iff (rst_locked)
      cfg_we |-> (cfg_ratio.div != '0) && (cfg_ratio.mul <= cfg_ratio.div)
   );

endmodule

//--- design/clk_domain_gen.sv
`timescale 1ns/1ps
`include "cm_defs.svh"

module clk_domain_gen (
   input  logic                   clk_buffered,
   input  logic                   rst_locked,
   input  cm_pkg::clk_ratio_t     ratio,
   input  logic                   relock,
   input  logic                   sys_halt,
   output cm_pkg::domain_status_t status
);

   localparam int LOCK_W = $clog2(`CM_LOCK_CYCLES + 1);
   localparam logic [LOCK_W-1:0] LOCK_LAST = LOCK_W'(`CM_LOCK_CYCLES - 1);

   logic [LOCK_W-1:0]      lock_cnt;
   logic                   locked_q;
   logic                   tick_q;
   logic [`CM_RATIO_W-1:0] acc;       // Fractional phase kept below div
   logic [`CM_RATIO_W:0]   sum;       // One extra bit for the carry
   logic [`CM_RATIO_W:0]   wrapped;
   logic                   overflow;
   logic                   halted;

   assign halted   = sys_halt && ratio.haltable;  // Gated buffer enable

   // Accumulator step applied only while locked and running
   assign sum      = {1'b0, acc} + {1'b0, ratio.mul};
   assign overflow = (sum >= {1'b0, ratio.div});
   assign wrapped  = sum - {1'b0, ratio.div};

   always_ff @(posedge clk_buffered) begin
      // A relock restarts the synthesizer just like reset
      if (rst_locked || relock) begin
         lock_cnt <= '0;
         locked_q <= 1'b0;
         acc      <= '0;
         tick_q   <= 1'b0;
      end else if (!locked_q) begin
         lock_cnt <= lock_cnt + 1'b1;
         if (lock_cnt == LOCK_LAST) begin
            locked_q <= 1'b1;
         end
         tick_q <= 1'b0;
      end else if (halted) begin
         tick_q <= 1'b0;   // Phase frozen
      end else begin
         if (overflow) begin
            acc <= wrapped[`CM_RATIO_W-1:0];
         end else begin
            acc <= sum[`CM_RATIO_W-1:0];
         end
         tick_q <= overflow;
      end
   end

   assign status.locked = locked_q;
   assign status.tick   = tick_q;

   // Downstream logic must never see an enable from an unlocked domain
   a_tick_needs_lock: assert property (
      @(posedge clk_buffered) disable iff (rst_locked)
      status.tick |-> status.locked
   );

   // Lock drops on the edge after a restart and is still low at the end of the lock window
   a_relock_drops_lock: assert property (
      @(posedge clk_buffered) disable iff (rst_locked)
      $past(relock) || $past(relock, `CM_LOCK_CYCLES) |-> !status.locked
   );

endmodule

//--- design/reset_sequencer.sv
`timescale 1ns/1ps
`include "cm_defs.svh"

module reset_sequencer (
   input  logic                       clk_buffered,
   input  logic                       rst_locked,
   input  logic [`CM_NUM_DOMAINS-1:0] domain_locked,
   input  logic                       cpu_reset,
   input  logic                       cpu_start,
   output logic                       rst_sys,
   output logic                       rst_cpu
);

   import cm_pkg::*;

   localparam int CNT_W = $clog2(`CM_RST_WIDTH);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CM_RST_WIDTH - 1);

   sys_state_e       sys_state;
   cpu_state_e       cpu_state;
   logic [CNT_W-1:0] sys_cnt;
   logic [CNT_W-1:0] cpu_cnt;
   logic             start_pend;  // cpu_start seen before the system ran
   logic             start_go;
   logic             sys_run;

   assign sys_run  = (sys_state == SYS_RUN);
   assign start_go = sys_run && (cpu_start || start_pend);

   // System side, released once every domain has locked
   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         sys_state <= SYS_WAIT_LOCK;
         sys_cnt   <= '0;
         rst_sys   <= 1'b1;
      end else begin
         case (sys_state)
            SYS_WAIT_LOCK: begin
               if (&domain_locked) begin
                  sys_state <= SYS_STRETCH;
                  sys_cnt   <= '0;
               end
            end
            SYS_STRETCH: begin
               sys_cnt <= sys_cnt + 1'b1;
               if (sys_cnt == CNT_LAST) begin  // Last of CM_RST_WIDTH cycles
                  sys_state <= SYS_RUN;
                  rst_sys   <= 1'b0;
               end
            end
            default: ;  // Later relocks leave rst_sys low
         endcase
      end
   end

   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         cpu_state  <= CPU_HOLD;
         cpu_cnt    <= '0;
         start_pend <= 1'b0;
         rst_cpu    <= 1'b1;
      end else if (cpu_reset) begin
         cpu_state  <= CPU_HOLD;   // Back to hold, wait for a new start
         start_pend <= 1'b0;
         rst_cpu    <= 1'b1;
      end else begin
         if (cpu_start && !sys_run) begin
            start_pend <= 1'b1;
         end
         case (cpu_state)
            CPU_HOLD: begin
               if (start_go) begin
                  cpu_state  <= CPU_STRETCH;
                  cpu_cnt    <= '0;
                  start_pend <= 1'b0;
               end
            end
            CPU_STRETCH: begin
               cpu_cnt <= cpu_cnt + 1'b1;
               if (cpu_cnt == CNT_LAST) begin
                  cpu_state <= CPU_RUN;
                  rst_cpu   <= 1'b0;
               end
            end
            default: ;
         endcase
      end
   end

   // CPU must never run ahead of the system it lives in
   a_cpu_under_sys: assert property (
      @(posedge clk_buffered) disable iff (rst_locked)
      rst_sys |-> rst_cpu
   );

endmodule

//--- design/clock_manager.sv
`timescale 1ns/1ps
`include "cm_defs.svh"

module clock_manager (
   input  logic                       clk_buffered,
   input  logic                       rst_locked,
   input  logic                       cfg_we,
   input  logic [`CM_IDX_W-1:0]       cfg_idx,
   input  cm_pkg::clk_ratio_t         cfg_ratio,
   input  logic                       sys_halt,
   input  logic                       cpu_reset,
   input  logic                       cpu_start,
   output logic [`CM_NUM_DOMAINS-1:0] clk_en,
   output logic [`CM_NUM_DOMAINS-1:0] domain_locked,
   output logic                       rst_sys,
   output logic                       rst_cpu
);

   import cm_pkg::*;

   clk_ratio_t                 ratios [`CM_NUM_DOMAINS];
   logic [`CM_NUM_DOMAINS-1:0] relock;
   domain_status_t             status [`CM_NUM_DOMAINS];

   ratio_config u_ratio_config (
      .clk_buffered (clk_buffered),
      .rst_locked   (rst_locked),
      .cfg_we       (cfg_we),
      .cfg_idx      (cfg_idx),
      .cfg_ratio    (cfg_ratio),
      .ratios       (ratios),
      .relock       (relock)
   );

   // One enable generator per domain
   for (genvar i = 0; i < `CM_NUM_DOMAINS; i++) begin : g_domain
      clk_domain_gen u_domain (
         .clk_buffered (clk_buffered),
         .rst_locked   (rst_locked),
         .ratio        (ratios[i]),
         .relock       (relock[i]),
         .sys_halt     (sys_halt),
         .status       (status[i])
      );

      assign clk_en[i]        = status[i].tick;
      assign domain_locked[i] = status[i].locked;
   end

   reset_sequencer u_reset_sequencer (
      .clk_buffered  (clk_buffered),
      .rst_locked    (rst_locked),
      .domain_locked (domain_locked),
      .cpu_reset     (cpu_reset),
      .cpu_start     (cpu_start),
      .rst_sys       (rst_sys),
      .rst_cpu       (rst_cpu)
   );

endmodule

//--- tb/tb_clock_manager.sv
`timescale 1ns/1ps
`include "cm_defs.svh"

module tb_clock_manager;

   import cm_pkg::*;

   localparam int    CLK_PERIOD = 20;
   localparam string CMD_FILE   = "tb/clock_manager_input.txt";

   // One parsed line of the command file
   typedef struct packed {
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
   } cmd_t;

   logic                       clk_buffered;
   logic                       rst_locked;
   logic                       cfg_we;
   logic [`CM_IDX_W-1:0]       cfg_idx;
   clk_ratio_t                 cfg_ratio;
   logic                       sys_halt;
   logic                       cpu_reset;
   logic                       cpu_start;
   logic [`CM_NUM_DOMAINS-1:0] clk_en;
   logic [`CM_NUM_DOMAINS-1:0] domain_locked;
   logic                       rst_sys;
   logic                       rst_cpu;

   cmd_t                       cmd_q [$];
   logic [`CM_NUM_DOMAINS-1:0] haltable_m;    // Last haltable bit per domain
   logic                       halt_level;
   logic                       sys_released;  // rst_sys expected low from here on
   logic                       cpu_held;      // rst_cpu expected high
   logic                       scan_done;
   int                         limit_cycles;

   clock_manager u_dut (
      .clk_buffered  (clk_buffered),
      .rst_locked    (rst_locked),
      .cfg_we        (cfg_we),
      .cfg_idx       (cfg_idx),
      .cfg_ratio     (cfg_ratio),
      .sys_halt      (sys_halt),
      .cpu_reset     (cpu_reset),
      .cpu_start     (cpu_start),
      .clk_en        (clk_en),
      .domain_locked (domain_locked),
      .rst_sys       (rst_sys),
      .rst_cpu       (rst_cpu)
   );

   initial begin
      clk_buffered = 1'b0;
      forever #(CLK_PERIOD / 2) clk_buffered = ~clk_buffered;
   end

   task automatic check_value(input int got, input int expected, input string what);
      if (got != expected) begin
         $display("ERR at time %0t: %s, got %0d expected %0d", $time, what, got, expected);
         $display("Test failures found");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   // Parse the whole file up front so the watchdog limit is known
   task automatic load_commands();
      int fd;
      int n;
      int ch;
      int a;
      int b;
      int c;
      int d;
      int sum;
      logic [7:0] op;
      cmd_t cmd;
      sum = 0;
      fd = $fopen(CMD_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the command file %s", CMD_FILE);
         $display("Test failures found");
         $fatal(1, "Missing command file");
      end else begin
         while ($fscanf(fd, " %c", op) == 1) begin
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            if (op == "#") begin
               ch = $fgetc(fd);
               while ((ch != 10) && (ch != -1)) begin
                  ch = $fgetc(fd);  // Skip comment text
               end
            end else begin
               case (op)
                  "W":      n = $fscanf(fd, " %d %d %d %d", a, b, c, d) - 4;
                  "C":      n = $fscanf(fd, " %d %d %d", a, b, c) - 3;
                  "H", "N": n = $fscanf(fd, " %d", a) - 1;
                  "R", "S": n = 0;
                  default:  n = -1;
               endcase
               if (n != 0) begin
                  $display("Malformed line in the command file at command %c", op);
                  $display("Test failures found");
                  $fatal(1, "Bad command file");
               end
               cmd = '{op: op, a: a, b: b, c: c, d: d};
               cmd_q.push_back(cmd);
               if (op == "N") sum += a;
               if (op == "C") sum += b;
            end
         end
         $fclose(fd);
         limit_cycles = sum + 200;
         scan_done    = 1'b1;
      end
   endtask

   // One clock with outputs sampled at the falling edge
   task automatic sample_cycle();
      @(negedge clk_buffered);
      if (sys_released) check_value(int'(rst_sys), 0, "rst_sys stays low after release");
      if (cpu_held) check_value(int'(rst_cpu), 1, "rst_cpu held high");
   endtask

   task automatic wait_for_release();
      sample_cycle();
      while (domain_locked != '1) begin
         check_value(int'(rst_sys), 1, "rst_sys high while domains lock");
         sample_cycle();
      end
      check_value(int'(rst_sys), 1, "rst_sys high at lock");
      repeat (`CM_RST_WIDTH) begin  // Stretch begins on the next edge
         sample_cycle();
         check_value(int'(rst_sys), 1, "rst_sys high during stretch");
      end
      sample_cycle();
      check_value(int'(rst_sys), 0, "rst_sys falls at end of stretch");
      sys_released = 1'b1;
   endtask

   task automatic write_ratio(input cmd_t cmd);
      clk_ratio_t                 r;
      logic [`CM_IDX_W-1:0]       idx;
      logic [`CM_NUM_DOMAINS-1:0] ticked;
      logic [`CM_NUM_DOMAINS-1:0] others;
      idx        = cmd.a[`CM_IDX_W-1:0];
      r.mul      = cmd.b[`CM_RATIO_W-1:0];
      r.div      = cmd.c[`CM_RATIO_W-1:0];
      r.haltable = cmd.d[0];
      @(posedge clk_buffered);
      cfg_we    <= 1'b1;
      cfg_idx   <= idx;
      cfg_ratio <= r;
      @(posedge clk_buffered);
      cfg_we <= 1'b0;
      haltable_m[idx] = r.haltable;
      sample_cycle();  // Relock pulse in flight
      check_value(int'(domain_locked[idx]), 1, "written domain locked until relock");
      ticked = '0;
      repeat (`CM_LOCK_CYCLES) begin
         sample_cycle();
         check_value(int'(domain_locked[idx]), 0, "written domain unlocked");
         check_value(int'(clk_en[idx]), 0, "no tick while locking");
         ticked = ticked | clk_en;
      end
      sample_cycle();
      check_value(int'(domain_locked[idx]), 1, "written domain locks again");
      ticked = ticked | clk_en;
      others = ~(`CM_NUM_DOMAINS'(1) << idx);
      if (halt_level) others = others & ~haltable_m;
      check_value(int'(ticked & others), int'(others), "other domains keep ticking");
   endtask

   task automatic count_ticks(input cmd_t cmd);
      logic [`CM_IDX_W-1:0] idx;
      int window;
      int expected;
      int cnt;
      int in_range;
      idx      = cmd.a[`CM_IDX_W-1:0];
      window   = int'(cmd.b);
      expected = int'(cmd.c);
      cnt      = 0;
      repeat (window) begin
         sample_cycle();
         if (clk_en[idx]) cnt++;
      end
      if (halt_level && haltable_m[idx]) begin
         check_value(cnt, 0, $sformatf("domain %0d ticks while halted", idx));
      end else begin
         in_range = int'((cnt >= expected) && (cnt <= expected + 1));
         check_value(in_range, 1, $sformatf("domain %0d counted %0d ticks, allowed %0d or %0d",
                                            idx, cnt, expected, expected + 1));
      end
   endtask

   task automatic run_command(input cmd_t cmd);
      case (cmd.op)
         "W": write_ratio(cmd);
         "C": count_ticks(cmd);
         "N": repeat (cmd.a) sample_cycle();
         "H": begin
            @(posedge clk_buffered);
            sys_halt <= cmd.a[0];
            halt_level = cmd.a[0];
            sample_cycle();  // First gated edge comes next
         end
         "R": begin
            @(posedge clk_buffered);
            cpu_reset <= 1'b1;
            @(posedge clk_buffered);
            cpu_reset <= 1'b0;
            cpu_held = 1'b1;
            sample_cycle();
         end
         "S": begin
            @(posedge clk_buffered);
            cpu_start <= 1'b1;
            @(posedge clk_buffered);
            cpu_start <= 1'b0;
            cpu_held = 1'b1;
            repeat (`CM_RST_WIDTH) sample_cycle();
            cpu_held = 1'b0;
            sample_cycle();
            check_value(int'(rst_cpu), 0, "rst_cpu falls after start stretch");
         end
         default: ;
      endcase
   endtask

   initial begin : watchdog
      wait (scan_done);
      #(limit_cycles * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
      $display("Test failures found");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      rst_locked   = 1'b1;
      cfg_we       = 1'b0;
      cfg_idx      = '0;
      cfg_ratio    = '0;
      sys_halt     = 1'b0;
      cpu_reset    = 1'b0;
      cpu_start    = 1'b0;
      haltable_m   = '1;  // Reset ratio is haltable
      halt_level   = 1'b0;
      sys_released = 1'b0;
      cpu_held     = 1'b1;
      scan_done    = 1'b0;
      load_commands();
      repeat (3) @(posedge clk_buffered);
      rst_locked <= 1'b0;
      wait_for_release();
      foreach (cmd_q[i]) begin
         run_command(cmd_q[i]);
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

//--- files.f
+incdir+include
design/cm_pkg.sv
design/ratio_config.sv
design/clk_domain_gen.sv
design/reset_sequencer.sv
design/clock_manager.sv
tb/tb_clock_manager.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_clock_manager \
   -f files.f -o sim_clock_manager || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_clock_manager > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"

//--- tb/clock_manager_input.txt
# W idx mul div haltable | H halt | R | S | N cycles | C idx window expected_ticks
# expected_ticks is floor(window*mul/div), a halted haltable domain must count zero
# Default ratio 1/2 on every domain
C 0 64 32
C 1 64 32
C 2 64 32
C 3 64 32
# Written ratios on separate domains, the last one not haltable
W 1 3 4 1
C 1 64 48
W 2 1 1 1
C 2 64 64
W 3 5 7 0
C 3 64 45
C 0 64 32
# Halt stops only the haltable domains
H 1
C 0 64 32
C 1 64 48
C 2 64 64
C 3 64 45
H 0
N 3
C 0 64 32
C 1 64 48
C 2 64 64
# CPU release, reset pulse and second release
S
N 10
R
N 20
S
N 5
C 3 64 45
